// ==== bench/lsuTests.txt ====
// Columns: op_size_atomic_address_data_expected, one hex word per test
// op: 1 load, 2 load that must hit, 3 store, 4 atomic, 5 invalidate, 6 poke, 7 peek
// size: 0 byte, 1 half, 2 word, 3 byte unsigned, 4 half unsigned; atomic: swap add xor and or min max minu maxu = 0..8
1_2_0_000002F8_00000000_D9D8DBDA
2_0_0_000002FD_00000000_FFFFFFDF
2_1_0_000002FE_00000000_FFFFDDDC
2_4_0_000002FA_00000000_0000D9D8
2_2_0_000002FC_00000000_DDDCDFDE
1_3_0_00000315_00000000_00000026
6_0_0_00000404_55667788_00000000
3_2_0_00000400_A1B2C3D4_00000000
7_0_0_00000400_00000000_A1B2C3D4
3_0_0_00000405_FFFFFFEE_00000000
2_2_0_00000404_00000000_5566EE88
3_1_0_00000406_1234BEEF_00000000
7_0_0_00000404_00000000_BEEFEE88
2_4_0_00000406_00000000_0000BEEF
6_0_0_00000500_00000010_00000000
4_2_0_00000500_80000005_00000010
4_2_1_00000500_00000003_80000005
4_2_2_00000500_0000000F_80000008
4_2_3_00000500_F0000003_80000007
4_2_4_00000500_00000030_80000003
4_2_5_00000500_80000000_80000033
4_2_6_00000500_00000007_80000000
4_2_7_00000500_FFFFFFF0_00000007
4_2_8_00000500_90000000_00000007
2_2_0_00000500_00000000_90000000
7_0_0_00000500_00000000_90000000
6_0_0_000002F8_CAFEF00D_00000000
2_2_0_000002F8_00000000_D9D8DBDA
5_0_0_00000000_00000000_00000000
1_2_0_000002F8_00000000_CAFEF00D
0_0_0_00000000_00000000_00000000

// ==== flist.f ====
hw/CachePkg.sv
hw/LsuPkg.sv
hw/StoreAligner.sv
hw/ByteBank.sv
hw/LoadAligner.sv
hw/TagArray.sv
hw/LsuControl.sv
hw/LoadStoreUnit.sv
bench/MemoryModel.sv
bench/LoadStoreUnitTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -j 0 \
    --top-module LoadStoreUnitTb -f flist.f

output="$(./obj_dir/VLoadStoreUnitTb)"
echo "$output"

if grep -q "Simulation finished: PASS" <<< "$output"; then
    exit 0
fi
exit 1

// ==== bench/LoadStoreUnitTb.sv ====
`default_nettype none

module LoadStoreUnitTb;
    timeunit 1ns;
    timeprecision 1ps;
    import CachePkg::*;
    import LsuPkg::*;

    localparam int MaxTests = 64;
    localparam int TimeoutCycles = 200;

    logic clk;
    logic rst;
    logic enable;
    LsuRequest request;
    logic done;
    logic [31:0] result;
    MemReadReq memRead;
    logic memReadGrant;
    line_t memReadData;
    MemWriteReq memWrite;
    logic memWriteGrant;

    // op, size, atomic op, address, data, expected
    logic [107:0] tests [MaxTests];
    int errorCount = 0;
    int passCount = 0;
    int failCount = 0;
    logic timedOut = 1'b0;

    LoadStoreUnit dut0 (
        .clk,
        .rst,
        .enable,
        .request,
        .done,
        .result,
        .memRead,
        .memReadGrant,
        .memReadData,
        .memWrite,
        .memWriteGrant
    );

    MemoryModel memory (
        .clk,
        .rst,
        .memRead,
        .memReadGrant,
        .memReadData,
        .memWrite,
        .memWriteGrant
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] %0d ns %s: got %h, expected %h", $time, name, actual, expected);
            errorCount++;
        end
    endtask

    // Low address byte mixed with the page bits above it
    function automatic logic [7:0] patternByte(input logic [11:0] addr);
        return addr[7:0] ^ {addr[11:8], addr[11:8]};
    endfunction

    task automatic fillMemory();
        logic [31:0] word;
        for (int a = 0; a < 4096; a += 4) begin
            for (int k = 0; k < 4; k++) begin
                word[k*8 +: 8] = patternByte(12'(a + k));
            end
            memory.writeWord(12'(a), word, 4'hF);
        end
    endtask

    function automatic string operationName(input logic [3:0] op);
        case (op)
            4'd1: return "load";
            4'd2: return "load hit";
            4'd3: return "store";
            4'd4: return "atomic";
            4'd5: return "invalidate";
            4'd6: return "poke";
            4'd7: return "peek";
            default: return "unknown";
        endcase
    endfunction

    // Latency counts cycles after the enable cycle
    task automatic issueRequest(input LsuRequest req, output logic [31:0] value,
                                output int latency, output logic sawRead);
        logic gotDone;
        gotDone = 1'b0;
        value = '0;
        latency = 0;
        sawRead = 1'b0;
        @(posedge clk);
        enable <= 1'b1;
        request <= req;
        while (!gotDone && latency <= TimeoutCycles) begin
            @(negedge clk);
            if (memRead.readReq) begin
                sawRead = 1'b1;
            end
            if (done) begin
                gotDone = 1'b1;
                value = result;
            end else begin
                latency++;
            end
        end
        @(posedge clk);
        enable <= 1'b0;
        if (!gotDone) begin
            $display("Timeout: no done within %0d cycles for a %s request",
                     TimeoutCycles, req.command.name());
            errorCount++;
            timedOut = 1'b1;
        end
    endtask

    task automatic reportTest(input int number, input string name, input int errorsBefore);
        if (errorCount == errorsBefore) begin
            passCount++;
            $display("Test %0d %s: ok", number, name);
        end else begin
            failCount++;
            $display("Test %0d %s: mismatch", number, name);
        end
    endtask

    initial begin
        LsuRequest req;
        logic [107:0] entry;
        logic [3:0] op;
        logic [31:0] value;
        int latency;
        logic sawRead;
        int errorsBefore;

        rst <= 1'b1;
        enable <= 1'b0;
        request <= '0;
        for (int i = 0; i < MaxTests; i++) begin
            tests[i] = '0;
        end
        $readmemh("bench/lsuTests.txt", tests);
        fillMemory();

        repeat (5) begin
            @(posedge clk);
        end
        rst <= 1'b0;

        errorsBefore = errorCount;
        repeat (3) begin
            @(negedge clk);
            checkValue("done", 32'(done), 32'd0);
            checkValue("memRead.readReq", 32'(memRead.readReq), 32'd0);
            checkValue("memWrite.writeReq", 32'(memWrite.writeReq), 32'd0);
        end
        reportTest(0, "reset", errorsBefore);

        for (int i = 0; i < MaxTests; i++) begin
            entry = tests[i];
            op = entry[107:104];
            if (op == 4'd0 || timedOut) begin
                break;
            end
            errorsBefore = errorCount;
            req.command = CommandNone;
            req.size = AccessSize'(entry[102:100]);
            req.atomicOp = AtomicOp'(entry[99:96]);
            req.addr = entry[95:64];
            req.storeData = entry[63:32];
            case (op)
                4'd1, 4'd2: begin
                    req.command = CommandLoad;
                    issueRequest(req, value, latency, sawRead);
                    checkValue("result", value, entry[31:0]);
                    if (op == 4'd2) begin
                        checkValue("hit latency", 32'(latency), 32'd1);
                        checkValue("memRead.readReq", 32'(sawRead), 32'd0);
                    end else begin
                        checkValue("memRead.readReq", 32'(sawRead), 32'd1);
                    end
                end
                4'd3: begin
                    req.command = CommandStore;
                    issueRequest(req, value, latency, sawRead);
                end
                4'd4: begin
                    req.command = CommandAtomic;
                    issueRequest(req, value, latency, sawRead);
                    checkValue("result", value, entry[31:0]);
                end
                4'd5: begin
                    req.command = CommandInvalidate;
                    issueRequest(req, value, latency, sawRead);
                    checkValue("invalidate latency", 32'(latency), 32'd1);
                end
                4'd6: begin
                    memory.writeWord(entry[75:64], entry[63:32], 4'hF);
                end
                4'd7: begin
                    checkValue("memory word", memory.readWord(entry[75:64]), entry[31:0]);
                end
                default: begin
                    $display("Test %0d has an unknown operation code %h", i + 1, op);
                    errorCount++;
                end
            endcase
            reportTest(i + 1, operationName(op), errorsBefore);
        end

        $display("%0d tests passed, %0d tests failed", passCount, failCount);
        if (errorCount == 0 && !timedOut) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/MemoryModel.sv ====
`default_nettype none

module MemoryModel (
    input  logic clk,
    input  logic rst,
    input  CachePkg::MemReadReq memRead,
    output logic memReadGrant,
    output CachePkg::line_t memReadData,
    input  CachePkg::MemWriteReq memWrite,
    output logic memWriteGrant
);
    timeunit 1ns;
    timeprecision 1ps;
    import CachePkg::*;

    logic [7:0] storage [4096];
    logic readGrant = 1'b0;
    line_t readData = '0;
    logic writeGrant = 1'b0;

    assign memReadGrant = readGrant;
    assign memReadData = readData;
    assign memWriteGrant = writeGrant;

    function automatic line_t readLine(input logic [8:0] lineIndex);
        line_t data;
        for (int k = 0; k < 8; k++) begin
            data[k*8 +: 8] = storage[{lineIndex, 3'(k)}];
        end
        return data;
    endfunction

    function automatic logic [31:0] readWord(input logic [11:0] addr);
        logic [31:0] word;
        for (int k = 0; k < 4; k++) begin
            word[k*8 +: 8] = storage[{addr[11:2], 2'(k)}];
        end
        return word;
    endfunction

    task automatic writeWord(input logic [11:0] addr, input logic [31:0] word,
                             input logic [3:0] mask);
        for (int k = 0; k < 4; k++) begin
            if (mask[k]) begin
                storage[{addr[11:2], 2'(k)}] = word[k*8 +: 8];
            end
        end
    endtask

    // Each request waits a fresh random number of cycles before its grant pulse
    initial begin
        int readCount;
        int writeCount;
        readCount = 0;
        writeCount = 0;
        void'($urandom(74049));
        forever begin
            @(posedge clk);
            if (rst) begin
                readGrant <= 1'b0;
                writeGrant <= 1'b0;
                readCount = 0;
                writeCount = 0;
            end else begin
                if (readGrant) begin
                    readGrant <= 1'b0;
                end else if (memRead.readReq) begin
                    if (readCount == 0) begin
                        readCount = int'($urandom % 6) + 1;
                    end else if (readCount == 1) begin
                        readGrant <= 1'b1;
                        readData <= readLine(memRead.lineAddr[8:0]);
                        readCount = 0;
                    end else begin
                        readCount = readCount - 1;
                    end
                end
                if (writeGrant) begin
                    writeGrant <= 1'b0;
                end else if (memWrite.writeReq) begin
                    if (writeCount == 0) begin
                        writeCount = int'($urandom % 6) + 1;
                    end else if (writeCount == 1) begin
                        writeGrant <= 1'b1;
                        writeWord(memWrite.addr[11:0], memWrite.word, memWrite.mask);
                        writeCount = 0;
                    end else begin
                        writeCount = writeCount - 1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/LoadStoreUnit.sv ====
`default_nettype none

module LoadStoreUnit (
    input  logic clk,
    input  logic rst,
    input  logic enable,
    input  LsuPkg::LsuRequest request,
    output logic done,
    output logic [31:0] result,
    output CachePkg::MemReadReq memRead,
    input  logic memReadGrant,
    input  CachePkg::line_t memReadData,
    output CachePkg::MemWriteReq memWrite,
    input  logic memWriteGrant
);
    import CachePkg::*;
    import LsuPkg::*;

    LsuRequest held;
    index_t index;
    logic fillEnable;
    tag_t fillTag;
    logic invalidateAll;
    logic hit;
    BankWrite bankWrite;
    BankWrite storeWrite;
    line_t bankRead;
    logic [31:0] loadWord;
    logic [31:0] memWord;
    logic [3:0] memMask;
    MemWriteReq storeWord;

    assign storeWord = '{
        writeReq: 1'b1,
        addr: {held.addr[AddrWidth-1:2], 2'b00},
        word: memWord,
        mask: memMask
    };

    LsuControl control (
        .clk,
        .rst,
        .enable,
        .request,
        .hit,
        .loadWord,
        .storeWrite,
        .storeWord,
        .memReadGrant,
        .memReadData,
        .memWriteGrant,
        .held,
        .index,
        .fillEnable,
        .fillTag,
        .invalidateAll,
        .bankWrite,
        .memRead,
        .memWrite,
        .done,
        .result
    );

    TagArray tags (
        .clk,
        .rst,
        .index,
        .lookupTag(held.addr[AddrWidth-1:TagLsb]),
        .fillEnable,
        .fillTag,
        .invalidateAll,
        .hit
    );

    StoreAligner storeAligner (
        .held,
        .oldWord(loadWord),
        .storeWrite,
        .memWord,
        .memMask
    );

    // One bank per byte lane of the line
    for (genvar i = 0; i < LineBytes; i++) begin : bankLane
        ByteBank #(
            .IndexWidth(IndexWidth)
        ) bank (
            .clk,
            .index,
            .writeEnable(bankWrite.byteMask[i]),
            .writeByte(bankWrite.lane[i*8 +: 8]),
            .readByte(bankRead[i*8 +: 8])
        );
    end

    LoadAligner loadAligner (
        .lane(bankRead),
        .offset(held.addr[OffsetWidth-1:0]),
        .size(held.size),
        .loadWord
    );

endmodule

`default_nettype wire

// ==== hw/LsuControl.sv ====
`default_nettype none

module LsuControl (
    input  logic clk,
    input  logic rst,
    input  logic enable,
    input  LsuPkg::LsuRequest request,
    input  logic hit,
    input  logic [31:0] loadWord,
    input  CachePkg::BankWrite storeWrite,
    input  CachePkg::MemWriteReq storeWord,
    input  logic memReadGrant,
    input  CachePkg::line_t memReadData,
    input  logic memWriteGrant,
    output LsuPkg::LsuRequest held,
    output CachePkg::index_t index,
    output logic fillEnable,
    output CachePkg::tag_t fillTag,
    output logic invalidateAll,
    output CachePkg::BankWrite bankWrite,
    output CachePkg::MemReadReq memRead,
    output CachePkg::MemWriteReq memWrite,
    output logic done,
    output logic [31:0] result
);
    import CachePkg::*;
    import LsuPkg::*;

    LsuState state;
    LsuState nextState;
    MemWriteReq pendingWrite;
    logic [31:0] savedWord;
    logic lookupDone;

    // Commands that finish in Lookup without touching memory
    always_comb begin
        unique case (held.command)
            CommandNone, CommandInvalidate: lookupDone = 1'b1;
            CommandLoad:                    lookupDone = hit;
            default:                        lookupDone = 1'b0;
        endcase
    end

    always_comb begin
        nextState = state;
        unique case (state)
            StateIdle: begin
                if (enable) begin
                    nextState = StateLookup;
                end
            end
            StateLookup: begin
                if (lookupDone) begin
                    nextState = StateIdle;
                end else if (!hit) begin
                    nextState = StateRefill;
                end else begin
                    nextState = StateStore;
                end
            end
            StateRefill: begin
                if (memReadGrant) begin
                    nextState = StateLookup;
                end
            end
            StateStore: begin
                nextState = StateWriteThrough;
            end
            StateWriteThrough: begin
                if (memWriteGrant) begin
                    nextState = StateIdle;
                end
            end
            default: begin
                nextState = StateIdle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= StateIdle;
        end else begin
            state <= nextState;
        end
    end

    always_ff @(posedge clk) begin
        if (state == StateIdle && enable) begin
            held <= request;
        end
        // Old word for the atomic result, before Store overwrites the line
        if (state == StateLookup) begin
            savedWord <= loadWord;
        end
        // Banks read back the merged line after Store, so keep the word here
        if (state == StateStore) begin
            pendingWrite <= storeWord;
        end
    end

    always_comb begin
        // Arrays see the incoming address while idle
        if (state == StateIdle) begin
            index = request.addr[IndexMsb:IndexLsb];
        end else begin
            index = held.addr[IndexMsb:IndexLsb];
        end

        fillEnable = (state == StateRefill) && memReadGrant;
        fillTag = held.addr[AddrWidth-1:TagLsb];
        invalidateAll = (state == StateLookup) && (held.command == CommandInvalidate);

        if (fillEnable) begin
            bankWrite.lane = memReadData;
            bankWrite.byteMask = '1;
        end else if (state == StateStore) begin
            bankWrite = storeWrite;
        end else begin
            bankWrite.lane = '0;
            bankWrite.byteMask = '0;
        end

        memRead.readReq = (state == StateRefill);
        memRead.lineAddr = held.addr[AddrWidth-1:OffsetWidth];

        memWrite = pendingWrite;
        memWrite.writeReq = pendingWrite.writeReq && (state == StateWriteThrough);

        done = ((state == StateLookup) && lookupDone) ||
               ((state == StateWriteThrough) && memWriteGrant);
        result = (held.command == CommandAtomic) ? savedWord : loadWord;
    end

endmodule

`default_nettype wire

// ==== hw/TagArray.sv ====
`default_nettype none

module TagArray (
    input  logic clk,
    input  logic rst,
    input  CachePkg::index_t index,
    input  CachePkg::tag_t lookupTag,
    input  logic fillEnable,
    input  CachePkg::tag_t fillTag,
    input  logic invalidateAll,
    output logic hit
);
    import CachePkg::*;

    logic [LineCount-1:0] valid;
    tag_t tags [LineCount];
    index_t readIndex;
    tag_t readTag;

    // All lines drop in a single cycle
    always_ff @(posedge clk) begin
        if (rst || invalidateAll) begin
            valid <= '0;
        end else if (fillEnable) begin
            valid[index] <= 1'b1;
        end
    end

    // Same write-first read as the data banks
    always_ff @(posedge clk) begin
        if (fillEnable) begin
            tags[index] <= fillTag;
            readTag <= fillTag;
        end else begin
            readTag <= tags[index];
        end
        readIndex <= index;
    end

    assign hit = valid[readIndex] && (readTag == lookupTag);

endmodule

`default_nettype wire

// ==== hw/LoadAligner.sv ====
`default_nettype none

module LoadAligner (
    input  CachePkg::line_t lane,
    input  logic [CachePkg::OffsetWidth-1:0] offset,
    input  LsuPkg::AccessSize size,
    output logic [31:0] loadWord
);
    import CachePkg::*;
    import LsuPkg::*;

    line_t shifted;

    always_comb begin
        // Addressed byte moves down to lane zero
        shifted = lane >> {offset, 3'b000};

        unique case (size)
            SizeByte: begin
                loadWord = {{24{shifted[7]}}, shifted[7:0]};
            end
            SizeHalf: begin
                loadWord = {{16{shifted[15]}}, shifted[15:0]};
            end
            SizeWord: begin
                loadWord = shifted[31:0];
            end
            SizeByteU: begin
                loadWord = {24'h000000, shifted[7:0]};
            end
            SizeHalfU: begin
                loadWord = {16'h0000, shifted[15:0]};
            end
            default: begin
                loadWord = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/ByteBank.sv ====
`default_nettype none

module ByteBank #(
    parameter int IndexWidth = CachePkg::IndexWidth
) (
    input  logic clk,
    input  logic [IndexWidth-1:0] index,
    input  logic writeEnable,
    input  logic [7:0] writeByte,
    output logic [7:0] readByte
);

    logic [7:0] storage [2**IndexWidth];

    // Write-first, so a refilled byte is visible on the next cycle
    always_ff @(posedge clk) begin
        if (writeEnable) begin
            storage[index] <= writeByte;
            readByte <= writeByte;
        end else begin
            readByte <= storage[index];
        end
    end

endmodule

`default_nettype wire

// ==== hw/StoreAligner.sv ====
`default_nettype none

module StoreAligner (
    input  LsuPkg::LsuRequest held,
    input  logic [31:0] oldWord,
    output CachePkg::BankWrite storeWrite,
    output logic [31:0] memWord,
    output logic [3:0] memMask
);
    import CachePkg::*;
    import LsuPkg::*;

    logic [31:0] storeValue;
    logic [3:0] sizeMask;
    logic [OffsetWidth-1:0] offset;

    // regValue is the register operand, memValue the old memory word
    function automatic logic [31:0] atomicAlu(AtomicOp op, logic [31:0] regValue,
                                              logic [31:0] memValue);
        unique case (op)
            AtomicSwap: return regValue;
            AtomicAdd:  return regValue + memValue;
            AtomicXor:  return regValue ^ memValue;
            AtomicAnd:  return regValue & memValue;
            AtomicOr:   return regValue | memValue;
            AtomicMin:  return ($signed(regValue) < $signed(memValue)) ? regValue : memValue;
            AtomicMax:  return ($signed(regValue) > $signed(memValue)) ? regValue : memValue;
            AtomicMinu: return (regValue < memValue) ? regValue : memValue;
            AtomicMaxu: return (regValue > memValue) ? regValue : memValue;
            default:    return regValue;
        endcase
    endfunction

    function automatic logic [3:0] maskForSize(AccessSize size);
        unique case (size)
            SizeByte, SizeByteU: return 4'b0001;
            SizeHalf, SizeHalfU: return 4'b0011;
            SizeWord:            return 4'b1111;
            default:             return 4'b0000;
        endcase
    endfunction

    always_comb begin
        if (held.command == CommandAtomic) begin
            storeValue = atomicAlu(held.atomicOp, held.storeData, oldWord);
        end else begin
            storeValue = held.storeData;
        end
        sizeMask = maskForSize(held.size);
        offset = held.addr[OffsetWidth-1:0];

        // Lanes of the whole line
        storeWrite.lane = line_t'(storeValue) << {offset, 3'b000};
        storeWrite.byteMask = byteMask_t'(sizeMask) << offset;

        // Lanes of the aligned memory word
        memWord = storeValue << {offset[1:0], 3'b000};
        memMask = sizeMask << offset[1:0];
    end

endmodule

`default_nettype wire

// ==== hw/LsuPkg.sv ====
`default_nettype none

package LsuPkg;

    typedef enum logic [2:0] {
        CommandNone,
        CommandLoad,
        CommandStore,
        CommandAtomic,
        CommandInvalidate
    } LsuCommand;

    // ByteU and HalfU are the zero-extending loads
    typedef enum logic [2:0] {
        SizeByte,
        SizeHalf,
        SizeWord,
        SizeByteU,
        SizeHalfU
    } AccessSize;

    typedef enum logic [3:0] {
        AtomicSwap,
        AtomicAdd,
        AtomicXor,
        AtomicAnd,
        AtomicOr,
        AtomicMin,
        AtomicMax,
        AtomicMinu,
        AtomicMaxu
    } AtomicOp;

    typedef enum logic [2:0] {
        StateIdle,
        StateLookup,
        StateRefill,
        StateStore,
        StateWriteThrough
    } LsuState;

    typedef struct packed {
        LsuCommand command;
        AccessSize size;
        AtomicOp atomicOp;
        logic [CachePkg::AddrWidth-1:0] addr;
        logic [31:0] storeData;
    } LsuRequest;

endpackage

`default_nettype wire

// ==== hw/CachePkg.sv ====
`default_nettype none

package CachePkg;

    localparam int LineBytes = 8;
    localparam int LineWidth = LineBytes * 8;
    localparam int IndexWidth = 4;
    localparam int LineCount = 2 ** IndexWidth;
    localparam int OffsetWidth = 3;
    localparam int AddrWidth = 32;
    localparam int TagWidth = AddrWidth - IndexWidth - OffsetWidth;

    // Field positions inside a physical address
    localparam int IndexLsb = OffsetWidth;
    localparam int IndexMsb = OffsetWidth + IndexWidth - 1;
    localparam int TagLsb = OffsetWidth + IndexWidth;

    typedef logic [AddrWidth-OffsetWidth-1:0] lineAddr_t;
    typedef logic [IndexWidth-1:0] index_t;
    typedef logic [TagWidth-1:0] tag_t;
    typedef logic [LineWidth-1:0] line_t;
    typedef logic [LineBytes-1:0] byteMask_t;

    typedef struct packed {
        logic readReq;
        lineAddr_t lineAddr;
    } MemReadReq;

    // Word write with byte enables, addr has its low two bits clear
    typedef struct packed {
        logic writeReq;
        logic [AddrWidth-1:0] addr;
        logic [31:0] word;
        logic [3:0] mask;
    } MemWriteReq;

    typedef struct packed {
        line_t lane;
        byteMask_t byteMask;
    } BankWrite;

endpackage

`default_nettype wire
